/* design/rate_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rate controller package
// widths, 12.4 fixed-point format and IMU clamp limit shared by the
// body-frame rate controller
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rate_ctrl_pkg;

	// rates, targets, errors and outputs
	localparam int rate_width = 16;

	// signed 12.4 fixed point
	localparam int frac_bits = 4;

	// gain, shift and accumulator widths
	localparam int gain_width  = 16;
	localparam int shift_width = 4;
	localparam int acc_width   = 32;

	// degrees per second in 12.4
	typedef logic signed [rate_width-1:0] rate_t;

	// unsigned gain multiplier
	typedef logic [gain_width-1:0] gain_t;

	// arithmetic right-shift applied after each gain
	typedef logic [shift_width-1:0] shift_t;

	// products and integral
	typedef logic signed [acc_width-1:0] acc_t;

	// IMU readings beyond 25 deg/s are not trusted
	localparam rate_t imu_clamp_limit = rate_t'(25 <<< frac_bits);

endpackage

`default_nettype wire

/* design/rate_input_latch.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rate input latch
// captures targets and IMU rates at cycle start, clamps and sign-corrects
// the IMU rates and folds the angle errors into roll and pitch targets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rate_input_latch import rate_ctrl_pkg::*; (
	input  logic  us_clk,
	input  logic  resetn,
	input  logic  cycle_start,
	input  rate_t yaw_target,
	input  rate_t roll_target,
	input  rate_t pitch_target,
	input  rate_t roll_angle_error,
	input  rate_t pitch_angle_error,
	input  rate_t yaw_rotation,
	input  rate_t roll_rotation,
	input  rate_t pitch_rotation,
	output rate_t yaw_target_q,
	output rate_t roll_target_q,
	output rate_t pitch_target_q,
	output rate_t yaw_actual_q,
	output rate_t roll_actual_q,
	output rate_t pitch_actual_q,
	output logic  sample_valid
);

	// symmetric clamp to +-imu_clamp_limit
	function automatic rate_t clamp_imu(input rate_t v);
		if (v > imu_clamp_limit)
			return imu_clamp_limit;
		else if (v < -imu_clamp_limit)
			return -imu_clamp_limit;
		else
			return v;
	endfunction

	// target plus angle error saturated back to 16 bits
	function automatic rate_t add_sat(input rate_t a, input rate_t b);
		logic signed [rate_width:0] sum;
		sum = {a[rate_width-1], a} + {b[rate_width-1], b};
		if (sum[rate_width] != sum[rate_width-1])
			return sum[rate_width] ? {1'b1, {(rate_width-1){1'b0}}}
			                       : {1'b0, {(rate_width-1){1'b1}}};
		else
			return sum[rate_width-1:0];
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			yaw_target_q   <= '0;
			roll_target_q  <= '0;
			pitch_target_q <= '0;
			yaw_actual_q   <= '0;
			roll_actual_q  <= '0;
			pitch_actual_q <= '0;
		end else if (cycle_start) begin
			yaw_target_q   <= yaw_target;
			roll_target_q  <= add_sat(roll_target, roll_angle_error);
			pitch_target_q <= add_sat(pitch_target, pitch_angle_error);
			yaw_actual_q   <= clamp_imu(yaw_rotation);
			// roll IMU is mounted flipped so negate after the clamp
			roll_actual_q  <= -clamp_imu(roll_rotation);
			pitch_actual_q <= clamp_imu(pitch_rotation);
		end
	end

	// PIDs see the latched values one cycle later
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			sample_valid <= 1'b0;
		else
			sample_valid <= cycle_start;
	end

endmodule

`default_nettype wire

/* design/axis_rate_pid.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// axis rate PID
// two-stage PID step for one axis with terms and integral in stage 1
// and the limited sum into rate_out in stage 2
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module axis_rate_pid import rate_ctrl_pkg::*; #(
	parameter gain_t  k_p       = 16'd4,
	parameter gain_t  k_i       = 16'd0,
	parameter gain_t  k_d       = 16'd0,
	parameter shift_t shift     = 4'd4,
	parameter rate_t  rate_min  = -16'sd4000,
	parameter rate_t  rate_max  = 16'sd4000,
	parameter acc_t   int_limit = 32'sd2000
) (
	input  logic  us_clk,
	input  logic  resetn,
	input  logic  sample_valid,
	input  rate_t target,
	input  rate_t actual,
	output rate_t rate_out,
	output logic  axis_done
);

	// gains as signed so the products keep their sign
	localparam acc_t kp_s = acc_t'(k_p);
	localparam acc_t ki_s = acc_t'(k_i);
	localparam acc_t kd_s = acc_t'(k_d);

	// persistent state
	acc_t integral;
	acc_t prev_error;

	// stage 1 combinational
	acc_t error;
	acc_t int_sum;
	acc_t int_next;
	acc_t p_prod;
	acc_t i_prod;
	acc_t d_prod;

	// stage 1 registers
	acc_t p_term;
	acc_t i_term;
	acc_t d_term;
	logic s1_valid;

	// stage 2 combinational
	acc_t sum;
	acc_t sum_lim;

	always_comb begin
		error   = acc_t'(target) - acc_t'(actual);
		int_sum = integral + error;
		if (int_sum > int_limit)
			int_next = int_limit;
		else if (int_sum < -int_limit)
			int_next = -int_limit;
		else
			int_next = int_sum;
		p_prod = error * kp_s;
		i_prod = int_next * ki_s;
		d_prod = (error - prev_error) * kd_s;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			integral   <= '0;
			prev_error <= '0;
			s1_valid   <= 1'b0;
		end else begin
			s1_valid <= sample_valid;
			if (sample_valid) begin
				integral   <= int_next;
				prev_error <= error;
			end
		end
	end

	// shifted terms loaded with each sample
	always_ff @(posedge us_clk) begin
		if (sample_valid) begin
			p_term <= p_prod >>> shift;
			i_term <= i_prod >>> shift;
			d_term <= d_prod >>> shift;
		end
	end

	always_comb begin
		sum = p_term + i_term + d_term;
		if (sum > acc_t'(rate_max))
			sum_lim = acc_t'(rate_max);
		else if (sum < acc_t'(rate_min))
			sum_lim = acc_t'(rate_min);
		else
			sum_lim = sum;
	end

	// rate_out held until the next step
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			rate_out  <= '0;
			axis_done <= 1'b0;
		end else begin
			axis_done <= s1_valid;
			if (s1_valid)
				rate_out <= rate_t'(sum_lim);
		end
	end

endmodule

`default_nettype wire

/* design/rate_cycle_sequencer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rate cycle sequencer
// accepts a start only when idle and merges the axis done strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rate_cycle_sequencer (
	input  logic us_clk,
	input  logic resetn,
	input  logic start,
	input  logic yaw_done,
	input  logic roll_done,
	input  logic pitch_done,
	output logic cycle_start,
	output logic complete
);

	typedef enum logic {st_idle, st_busy} state_t;

	state_t state;
	logic   yaw_seen, roll_seen, pitch_seen;
	logic   all_done;

	// starts while busy are dropped
	assign cycle_start = start && (state == st_idle);

	// a strobe arriving this cycle counts as seen
	assign all_done = (yaw_seen || yaw_done) && (roll_seen || roll_done) &&
	                  (pitch_seen || pitch_done);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state      <= st_idle;
			yaw_seen   <= 1'b0;
			roll_seen  <= 1'b0;
			pitch_seen <= 1'b0;
			complete   <= 1'b0;
		end else begin
			complete <= 1'b0;
			case (state)
				st_idle: begin
					if (start)
						state <= st_busy;
				end
				st_busy: begin
					if (all_done) begin
						complete   <= 1'b1;
						yaw_seen   <= 1'b0;
						roll_seen  <= 1'b0;
						pitch_seen <= 1'b0;
						state      <= st_idle;
					end else begin
						yaw_seen   <= yaw_seen || yaw_done;
						roll_seen  <= roll_seen || roll_done;
						pitch_seen <= pitch_seen || pitch_done;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/body_rate_controller.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// body-frame rate controller
// turns target and measured body rates into yaw, roll and pitch rate
// commands for the motor mixer, one PID step per start strobe
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module body_rate_controller import rate_ctrl_pkg::*; #(
	parameter gain_t  yaw_k_p        = 16'd4,
	parameter gain_t  yaw_k_i        = 16'd0,
	parameter gain_t  yaw_k_d        = 16'd0,
	parameter shift_t yaw_shift      = 4'd4,
	parameter rate_t  yaw_rate_min   = -16'sd4000,
	parameter rate_t  yaw_rate_max   = 16'sd4000,
	parameter gain_t  roll_k_p       = 16'd4,
	parameter gain_t  roll_k_i       = 16'd0,
	parameter gain_t  roll_k_d       = 16'd0,
	parameter shift_t roll_shift     = 4'd4,
	parameter rate_t  roll_rate_min  = -16'sd4000,
	parameter rate_t  roll_rate_max  = 16'sd4000,
	parameter gain_t  pitch_k_p      = 16'd4,
	parameter gain_t  pitch_k_i      = 16'd0,
	parameter gain_t  pitch_k_d      = 16'd0,
	parameter shift_t pitch_shift    = 4'd4,
	parameter rate_t  pitch_rate_min = -16'sd4000,
	parameter rate_t  pitch_rate_max = 16'sd4000,
	// integral bound shared by every axis
	parameter acc_t   int_limit      = 32'sd2000
) (
	input  logic  us_clk,
	input  logic  resetn,
	input  logic  start,
	input  rate_t yaw_target,
	input  rate_t roll_target,
	input  rate_t pitch_target,
	input  rate_t roll_angle_error,
	input  rate_t pitch_angle_error,
	input  rate_t yaw_rotation,
	input  rate_t roll_rotation,
	input  rate_t pitch_rotation,
	output rate_t yaw_rate_out,
	output rate_t roll_rate_out,
	output rate_t pitch_rate_out,
	output logic  complete
);

	logic  cycle_start;
	logic  sample_valid;
	logic  yaw_done, roll_done, pitch_done;
	rate_t yaw_target_q, roll_target_q, pitch_target_q;
	rate_t yaw_actual_q, roll_actual_q, pitch_actual_q;

	rate_cycle_sequencer u_sequencer (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.yaw_done    (yaw_done),
		.roll_done   (roll_done),
		.pitch_done  (pitch_done),
		.cycle_start (cycle_start),
		.complete    (complete)
	);

	rate_input_latch u_latch (
		.us_clk            (us_clk),
		.resetn            (resetn),
		.cycle_start       (cycle_start),
		.yaw_target        (yaw_target),
		.roll_target       (roll_target),
		.pitch_target      (pitch_target),
		.roll_angle_error  (roll_angle_error),
		.pitch_angle_error (pitch_angle_error),
		.yaw_rotation      (yaw_rotation),
		.roll_rotation     (roll_rotation),
		.pitch_rotation    (pitch_rotation),
		.yaw_target_q      (yaw_target_q),
		.roll_target_q     (roll_target_q),
		.pitch_target_q    (pitch_target_q),
		.yaw_actual_q      (yaw_actual_q),
		.roll_actual_q     (roll_actual_q),
		.pitch_actual_q    (pitch_actual_q),
		.sample_valid      (sample_valid)
	);

	// three axes run side by side with equal latency
	axis_rate_pid #(
		.k_p (yaw_k_p), .k_i (yaw_k_i), .k_d (yaw_k_d), .shift (yaw_shift),
		.rate_min (yaw_rate_min), .rate_max (yaw_rate_max), .int_limit (int_limit)
	) u_yaw_pid (
		.us_clk (us_clk), .resetn (resetn), .sample_valid (sample_valid),
		.target (yaw_target_q), .actual (yaw_actual_q),
		.rate_out (yaw_rate_out), .axis_done (yaw_done)
	);

	axis_rate_pid #(
		.k_p (roll_k_p), .k_i (roll_k_i), .k_d (roll_k_d), .shift (roll_shift),
		.rate_min (roll_rate_min), .rate_max (roll_rate_max), .int_limit (int_limit)
	) u_roll_pid (
		.us_clk (us_clk), .resetn (resetn), .sample_valid (sample_valid),
		.target (roll_target_q), .actual (roll_actual_q),
		.rate_out (roll_rate_out), .axis_done (roll_done)
	);

	axis_rate_pid #(
		.k_p (pitch_k_p), .k_i (pitch_k_i), .k_d (pitch_k_d), .shift (pitch_shift),
		.rate_min (pitch_rate_min), .rate_max (pitch_rate_max), .int_limit (int_limit)
	) u_pitch_pid (
		.us_clk (us_clk), .resetn (resetn), .sample_valid (sample_valid),
		.target (pitch_target_q), .actual (pitch_actual_q),
		.rate_out (pitch_rate_out), .axis_done (pitch_done)
	);

endmodule

`default_nettype wire

/* sim/rate_ctrl_tb_vectors.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rate controller test vectors
// stimulus and expected-output table, and the reference model that fills it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RATE_CTRL_TB_VECTORS_SVH
`define RATE_CTRL_TB_VECTORS_SVH

localparam int num_rows     = 24;
localparam int num_directed = 13;
// 25 deg/s in 12.4
localparam int imu_lim      = 25 * 16;

// columns 0 to 7 hold yaw, roll and pitch target, roll and pitch angle
// error, then yaw, roll and pitch rotation
rate_t stim_tab [0:num_rows-1][0:7];
// expected yaw, roll, pitch rate outputs after each row
rate_t expect_tab [0:num_rows-1][0:2];
int    gap_tab [0:num_rows-1];
bit    dbl_tab [0:num_rows-1];

// integral and previous error per axis carried from row to row
int model_integ [0:2];
int model_prev [0:2];

function automatic int sat_range(input int v, input int lo, input int hi);
	if (v > hi)
		return hi;
	else if (v < lo)
		return lo;
	else
		return v;
endfunction

// one PID step for one axis that also updates its state
function automatic int pid_model(input int axis, input int target, input int actual,
		input int kp, input int ki, input int kd, input int lim);
	int err;
	int integ;
	int sum;
	err   = target - actual;
	integ = sat_range(model_integ[axis] + err, -int_lim, int_lim);
	sum   = ((err * kp) >>> gain_shift) + ((integ * ki) >>> gain_shift) +
	        (((err - model_prev[axis]) * kd) >>> gain_shift);
	model_integ[axis] = integ;
	model_prev[axis]  = err;
	return sat_range(sum, -lim, lim);
endfunction

task automatic compute_expected();
	int row;
	int roll_act;
	for (row = 0; row < 3; row++) begin
		model_integ[row] = 0;
		model_prev[row]  = 0;
	end
	for (row = 0; row < num_rows; row++) begin
		// roll IMU reads flipped
		roll_act = -sat_range(int'(stim_tab[row][6]), -imu_lim, imu_lim);
		expect_tab[row][0] = rate_t'(pid_model(0, int'(stim_tab[row][0]),
			sat_range(int'(stim_tab[row][5]), -imu_lim, imu_lim),
			yaw_kp, yaw_ki, yaw_kd, yaw_lim));
		expect_tab[row][1] = rate_t'(pid_model(1,
			sat_range(int'(stim_tab[row][1]) + int'(stim_tab[row][3]), -32768, 32767),
			roll_act, roll_kp, roll_ki, roll_kd, tilt_lim));
		expect_tab[row][2] = rate_t'(pid_model(2,
			sat_range(int'(stim_tab[row][2]) + int'(stim_tab[row][4]), -32768, 32767),
			sat_range(int'(stim_tab[row][7]), -imu_lim, imu_lim),
			pitch_kp, pitch_ki, pitch_kd, tilt_lim));
	end
endtask

`endif

/* sim/tb_body_rate_controller.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// body rate controller testbench
// table-driven PID steps checked against a reference model, with
// latency and dropped-start checks on the cycle handshake
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_body_rate_controller import rate_ctrl_pkg::*; ();

	localparam int yaw_kp     = 4;
	localparam int yaw_ki     = 1;
	localparam int yaw_kd     = 2;
	localparam int roll_kp    = 6;
	localparam int roll_ki    = 1;
	localparam int roll_kd    = 3;
	localparam int pitch_kp   = 5;
	localparam int pitch_ki   = 2;
	localparam int pitch_kd   = 1;
	localparam int gain_shift = 4;
	localparam int yaw_lim    = 1000;
	localparam int tilt_lim   = 4000;
	localparam int int_lim    = 2000;

	logic   us_clk;
	logic   resetn;
	logic   start;
	rate_t  yaw_target, roll_target, pitch_target;
	rate_t  roll_angle_error, pitch_angle_error;
	rate_t  yaw_rotation, roll_rotation, pitch_rotation;
	rate_t  yaw_rate_out, roll_rate_out, pitch_rate_out;
	logic   complete;
	int     error_count;
	int     check_count;
	int     cycle_count;
	int     cycle_limit;
	bit     table_ready;
	integer seed;

	`include "rate_ctrl_tb_vectors.svh"

	body_rate_controller #(
		.yaw_k_p (gain_t'(yaw_kp)), .yaw_k_i (gain_t'(yaw_ki)), .yaw_k_d (gain_t'(yaw_kd)),
		.roll_k_p (gain_t'(roll_kp)), .roll_k_i (gain_t'(roll_ki)),
		.roll_k_d (gain_t'(roll_kd)),
		.pitch_k_p (gain_t'(pitch_kp)), .pitch_k_i (gain_t'(pitch_ki)),
		.pitch_k_d (gain_t'(pitch_kd)), .yaw_shift (shift_t'(gain_shift)),
		.roll_shift (shift_t'(gain_shift)), .pitch_shift (shift_t'(gain_shift)),
		.yaw_rate_min (rate_t'(-yaw_lim)), .yaw_rate_max (rate_t'(yaw_lim)),
		.roll_rate_min (rate_t'(-tilt_lim)), .roll_rate_max (rate_t'(tilt_lim)),
		.pitch_rate_min (rate_t'(-tilt_lim)), .pitch_rate_max (rate_t'(tilt_lim)),
		.int_limit (acc_t'(int_lim))
	) i_dut (
		.us_clk (us_clk), .resetn (resetn), .start (start),
		.yaw_target (yaw_target), .roll_target (roll_target), .pitch_target (pitch_target),
		.roll_angle_error (roll_angle_error), .pitch_angle_error (pitch_angle_error),
		.yaw_rotation (yaw_rotation), .roll_rotation (roll_rotation),
		.pitch_rotation (pitch_rotation), .yaw_rate_out (yaw_rate_out),
		.roll_rate_out (roll_rate_out), .pitch_rate_out (pitch_rate_out),
		.complete (complete)
	);

	initial begin
		us_clk = 1'b0;
		forever #2 us_clk = ~us_clk;
	end

	// watchdog limit is set once the table is known
	initial begin
		cycle_count = 0;
		wait (table_ready);
		while (cycle_count < cycle_limit) begin
			@(posedge us_clk);
			cycle_count++;
		end
		$display("run stopped at cycle %0d before the table was finished", cycle_count);
		$display("Some tests failed");
		$finish;
	end

	task automatic check_rate(input string name, input int step, input rate_t got,
			input rate_t exp);
		check_count++;
		assert (got == exp) else begin
			$display("[ERROR] %s at step %0d: expected %h, got %h", name, step, exp, got);
			error_count++;
		end
	endtask

	task automatic set_row(input int row, input int yt, input int rt, input int pt,
			input int re, input int pe, input int yr, input int rr, input int pr,
			input int gap, input bit dbl);
		stim_tab[row][0] = rate_t'(yt);
		stim_tab[row][1] = rate_t'(rt);
		stim_tab[row][2] = rate_t'(pt);
		stim_tab[row][3] = rate_t'(re);
		stim_tab[row][4] = rate_t'(pe);
		stim_tab[row][5] = rate_t'(yr);
		stim_tab[row][6] = rate_t'(rr);
		stim_tab[row][7] = rate_t'(pr);
		gap_tab[row]     = gap;
		dbl_tab[row]     = dbl;
	endtask

	task automatic build_table();
		int row;
		int col;
		set_row(0, 160, 320, -240, 32, -48, 80, 100, -64, 1, 1'b0);
		set_row(1, 160, 320, -240, 32, -48, 80, 100, -64, 0, 1'b0);
		// step change for the derivative term
		set_row(2, 480, -320, 400, 0, 64, 80, -200, 100, 2, 1'b0);
		// IMU beyond 25 deg/s with roll at the negative extremes
		set_row(3, 0, 160, 0, 0, 0, 1000, -2000, 32767, 1, 1'b0);
		set_row(4, 0, 0, 0, 0, 0, -32768, -32768, -900, 3, 1'b0);
		// constant error until the integral hits int_lim
		for (row = 5; row < 9; row++)
			set_row(row, 800, 1200, -1000, 0, 0, 0, 0, 0, 0, 1'b0);
		set_row(9, 20000, 30000, -30000, 5000, -5000, 0, 0, 0, 1, 1'b0);
		set_row(10, -20000, -30000, 30000, -5000, 5000, 0, 0, 0, 1, 1'b0);
		set_row(11, 240, -160, 96, 16, 0, 40, -40, 20, 2, 1'b1);
		set_row(12, 240, -160, 96, 16, 0, 40, -40, 20, 1, 1'b0);
		for (row = num_directed; row < num_rows; row++) begin
			for (col = 0; col < 8; col++)
				stim_tab[row][col] = rate_t'($random(seed) % 1600);
			gap_tab[row] = $random(seed) & 3;
			dbl_tab[row] = 1'b0;
		end
	endtask

	task automatic run_row(input int row);
		int waited;
		yaw_target        = stim_tab[row][0];
		roll_target       = stim_tab[row][1];
		pitch_target      = stim_tab[row][2];
		roll_angle_error  = stim_tab[row][3];
		pitch_angle_error = stim_tab[row][4];
		yaw_rotation      = stim_tab[row][5];
		roll_rotation     = stim_tab[row][6];
		pitch_rotation    = stim_tab[row][7];
		start = 1'b1;
		@(posedge us_clk);
		#1;
		// second strobe while busy carries a yaw target that must not be taken
		start = dbl_tab[row];
		if (dbl_tab[row])
			yaw_target = 16'sh7fff;
		waited = 0;
		while (!complete && waited < 3) begin
			@(posedge us_clk);
			#1;
			start = 1'b0;
			waited++;
		end
		check_count++;
		assert (complete && waited == 3) else begin
			$display("row %0d: complete not seen exactly 3 cycles after start", row);
			error_count++;
		end
		check_rate("yaw_rate_out", row + 1, yaw_rate_out, expect_tab[row][0]);
		check_rate("roll_rate_out", row + 1, roll_rate_out, expect_tab[row][1]);
		check_rate("pitch_rate_out", row + 1, pitch_rate_out, expect_tab[row][2]);
		repeat (gap_tab[row] + 1) begin
			@(posedge us_clk);
			#1;
			check_count++;
			assert (!complete) else begin
				$display("row %0d: complete high again without a new start", row);
				error_count++;
			end
		end
	endtask

	initial begin
		int row;
		int max_gap;
		seed = 32;
		error_count = 0;
		check_count = 0;
		resetn = 1'b0;
		start = 1'b0;
		yaw_target = '0;
		roll_target = '0;
		pitch_target = '0;
		roll_angle_error = '0;
		pitch_angle_error = '0;
		yaw_rotation = '0;
		roll_rotation = '0;
		pitch_rotation = '0;
		build_table();
		compute_expected();
		max_gap = 0;
		for (row = 0; row < num_rows; row++)
			if (gap_tab[row] > max_gap)
				max_gap = gap_tab[row];
		cycle_limit = num_rows * (4 + max_gap) + 100;
		table_ready = 1'b1;
		repeat (16) @(posedge us_clk);
		#1;
		resetn = 1'b1;
		@(posedge us_clk);
		#1;
		check_count++;
		assert (!complete) else begin
			$display("complete is high right after reset");
			error_count++;
		end
		check_rate("yaw_rate_out", 0, yaw_rate_out, '0);
		check_rate("roll_rate_out", 0, roll_rate_out, '0);
		check_rate("pitch_rate_out", 0, pitch_rate_out, '0);
		for (row = 0; row < num_rows; row++)
			run_row(row);
		$display("checks: %0d  errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+sim
design/rate_ctrl_pkg.sv
design/rate_input_latch.sv
design/axis_rate_pid.sv
design/rate_cycle_sequencer.sv
design/body_rate_controller.sv
sim/tb_body_rate_controller.sv

/* run_sim.sh */
#!/bin/sh
# build the body rate controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_body_rate_controller \
	-f filelist.f -Mdir obj_dir > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_body_rate_controller > sim.log 2>&1
cat sim.log

grep -qx "All tests passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
